/* build.f */
rx_pkg.sv
xfer_sequencer.sv
frame_word_mux.sv
sample_ram.sv
host_read_port.sv
rx_buffer_top.sv
tb_rx_buffer_assertions.sv
tb_rx_buffer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_rx_buffer
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rx_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// host reads use 2 cycles per word; the queue model must stay below 8192 words
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_rx_buffer;
	import rx_pkg::*;

	localparam int SAMP_GAP = 24;                       // cycles between rx_avail pulses
	localparam int WPS      = RX_CHANS * WORDS_PER_CHAN; // words per sample

	// host action after each frame
	localparam int ACT_READ     = 0;    // read every queued word
	localparam int ACT_READ_END = 1;    // read only after the last frame of the row
	localparam int ACT_CTR      = 2;    // read the buffer counter
	localparam int ACT_SRQ      = 3;    // srq twice, 1 then 0
	localparam int ACT_RESET    = 4;    // partial frame, reset, then read each frame

	////////////////////////////////////////////////////////////////////////////
	// row table: nsamps, frames, action, reset first, buf_ctr at row end
	////////////////////////////////////////////////////////////////////////////
	localparam int NUM_ROWS = 6;
	localparam int ROW_NSAMPS  [NUM_ROWS] = '{1, 5, 3, 2, 4, 6};
	localparam int ROW_FRAMES  [NUM_ROWS] = '{1, 3, 2, 2, 1, 2};
	localparam int ROW_ACT     [NUM_ROWS] = '{ACT_READ, ACT_READ_END, ACT_CTR,
	                                          ACT_SRQ, ACT_READ, ACT_RESET};
	localparam int ROW_RESET   [NUM_ROWS] = '{0, 1, 0, 0, 0, 0};
	localparam int ROW_CTR_END [NUM_ROWS] = '{1, 3, 5, 7, 8, 2};

	logic                                adc_clk = 1'b0;
	logic                                reset_bufs_A;
	logic                                rx_avail_i;
	logic [RX_CHANS*CHAN_IQ_BITS-1:0]    chan_iq_i;
	logic [TICKS_BITS-1:0]               ticks_i;
	logic                                set_nsamps_i;
	logic [NSAMPS_BITS-1:0]              nsamps_i;
	logic                                get_samp_i;
	logic                                get_buf_ctr_i;
	logic                                get_srq_i;
	logic                                rx_rd_o;
	logic [WORD_BITS-1:0]                rx_dout_o;
	logic                                srq_o;

	logic [31:0]          rng;          // xorshift state
	logic [WORD_BITS-1:0] exp_q [$];    // expected words in write order
	int                   model_ctr;    // frames since reset
	int                   err_cnt;
	int                   chk_cnt;

	rx_buffer_top dut_i (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.rx_avail_i    (rx_avail_i),
		.chan_iq_i     (chan_iq_i),
		.ticks_i       (ticks_i),
		.set_nsamps_i  (set_nsamps_i),
		.nsamps_i      (nsamps_i),
		.get_samp_i    (get_samp_i),
		.get_buf_ctr_i (get_buf_ctr_i),
		.get_srq_i     (get_srq_i),
		.rx_rd_o       (rx_rd_o),
		.rx_dout_o     (rx_dout_o),
		.srq_o         (srq_o)
	);

	always #20 adc_clk = ~adc_clk;  // 40 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_word(output logic [WORD_BITS-1:0] w);
		rng = xorshift32(rng);
		w   = rng[31:16];
	endtask

	task automatic check_value(input string name, input logic [WORD_BITS-1:0] got,
	                           input logic [WORD_BITS-1:0] exp);
		chk_cnt++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED t=%0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// the frame closes on frame_done, seen at the falling edge
	task automatic wait_frame_done();
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 64 && !seen; n++)
		begin
			@(negedge adc_clk);
			seen = dut_i.frame_done;
		end
		chk_cnt++;
		assert (seen)
		else
		begin
			$display("ERROR t=%0t frame_done did not pulse within 64 cycles", $time);
			err_cnt++;
		end
	endtask

	task automatic send_sample(input bit closing);
		logic [RX_CHANS*CHAN_IQ_BITS-1:0] iq;
		logic [TICKS_BITS-1:0]            tk;
		logic [WORD_BITS-1:0]             w;
		for (int c = 0; c < RX_CHANS; c++)
			for (int k = 0; k < WORDS_PER_CHAN; k++)
			begin
				draw_word(w);
				iq[c*CHAN_IQ_BITS + k*WORD_BITS +: WORD_BITS] = w;
				exp_q.push_back(w);     // ch order, then I Q IQ3
			end
		for (int k = 0; k < 3; k++)
		begin
			draw_word(w);
			tk[k*WORD_BITS +: WORD_BITS] = w;
		end
		if (closing)
		begin
			for (int k = 0; k < 3; k++)
				exp_q.push_back(tk[k*WORD_BITS +: WORD_BITS]);  // lsw first
			exp_q.push_back(16'(model_ctr));    // counter before increment
			model_ctr++;
		end
		@(posedge adc_clk);
		chan_iq_i  <= iq;
		ticks_i    <= tk;
		rx_avail_i <= 1'b1;
		@(posedge adc_clk);
		rx_avail_i <= 1'b0;
		chan_iq_i  <= ~iq;      // only the latched copy may reach the RAM
		ticks_i    <= ~tk;
		if (closing)
		begin
			wait_frame_done();
			repeat (4) @(posedge adc_clk);
		end
		else
			repeat (SAMP_GAP - 2) @(posedge adc_clk);
	endtask

	task automatic read_word();
		logic [WORD_BITS-1:0] exp;
		exp = exp_q.pop_front();
		@(posedge adc_clk);
		get_samp_i <= 1'b1;
		@(posedge adc_clk);
		get_samp_i <= 1'b0;
		@(negedge adc_clk);     // data valid the cycle after the strobe
		check_value("rx_rd_o", 16'(rx_rd_o), 16'd1);
		check_value("rx_dout_o", rx_dout_o, exp);
	endtask

	task automatic drain_words();
		while (exp_q.size() > 0)
			read_word();
	endtask

	task automatic read_counter(input int exp);
		@(posedge adc_clk);
		get_buf_ctr_i <= 1'b1;
		@(posedge adc_clk);
		get_buf_ctr_i <= 1'b0;
		@(negedge adc_clk);
		check_value("rx_rd_o", 16'(rx_rd_o), 16'd1);
		check_value("buf_ctr", rx_dout_o, 16'(exp));
	endtask

	task automatic query_srq(input bit exp);
		@(posedge adc_clk);
		get_srq_i <= 1'b1;
		@(posedge adc_clk);
		get_srq_i <= 1'b0;
		@(negedge adc_clk);
		check_value("srq_o", 16'(srq_o), 16'(exp));
		check_value("rx_rd_o", 16'(rx_rd_o), 16'd0);   // a query is no read
	endtask

	task automatic apply_reset();
		@(posedge adc_clk);
		reset_bufs_A <= 1'b1;
		repeat (4) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		exp_q.delete();         // buffer and counter start over
		model_ctr = 0;
	endtask

	task automatic set_nsamps(input int n);
		@(posedge adc_clk);
		set_nsamps_i <= 1'b1;
		nsamps_i     <= NSAMPS_BITS'(n);
		@(posedge adc_clk);
		set_nsamps_i <= 1'b0;
	endtask

	task automatic run_row(input int r);
		if (ROW_RESET[r] != 0)
			apply_reset();
		set_nsamps(ROW_NSAMPS[r]);
		if (ROW_ACT[r] == ACT_RESET)
		begin
			send_sample(1'b0);  // open a frame, then drop it
			send_sample(1'b0);
			apply_reset();      // nsamps is kept
		end
		for (int f = 0; f < ROW_FRAMES[r]; f++)
		begin
			for (int s = 0; s < ROW_NSAMPS[r]; s++)
				send_sample(s == ROW_NSAMPS[r] - 1);
			case (ROW_ACT[r])
				ACT_CTR:      read_counter(model_ctr);
				ACT_READ_END: if (f == ROW_FRAMES[r] - 1) drain_words();
				ACT_SRQ:
				begin
					query_srq(1'b1);
					query_srq(1'b0);    // nothing new since the last query
				end
				default:      drain_words();
			endcase
		end
		read_counter(ROW_CTR_END[r]);
	endtask

	// cycles for the whole table, reads take 2 cycles per word
	function automatic int budget_cycles();
		int total;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total += ROW_FRAMES[r] * (ROW_NSAMPS[r] * SAMP_GAP
			         + 2 * (WPS * ROW_NSAMPS[r] + 4) + 40) + 3 * SAMP_GAP;
		return total + 2000;    // margin for leftover reads and resets
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		reset_bufs_A  = 1'b1;
		rx_avail_i    = 1'b0;
		chan_iq_i     = '0;
		ticks_i       = '0;
		set_nsamps_i  = 1'b0;
		nsamps_i      = '0;
		get_samp_i    = 1'b0;
		get_buf_ctr_i = 1'b0;
		get_srq_i     = 1'b0;
		rng           = 32'd69001;
		model_ctr     = 0;
		err_cnt       = 0;
		chk_cnt       = 0;
		repeat (4) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		query_srq(1'b0);        // no frame yet
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		err_cnt += dut_i.seq_i.seq_chk_i.fail_cnt;  // bound SVA failures
		$display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		limit = budget_cycles();
		repeat (limit) @(posedge adc_clk);
		$display("ERROR watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_rx_buffer_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// bound into xfer_sequencer; all but the reset check are off during reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_rx_buffer_assertions (
	input wire                          adc_clk,
	input wire                          reset_bufs_A,
	input wire                          wr_o,
	input wire [rx_pkg::CHAN_BITS-1:0]  chan_o,
	input wire [1:0]                    word_o,
	input wire                          frame_done_o
);
	import rx_pkg::*;

	int fail_cnt = 0;   // summed into the testbench error count

	// reset drops any transfer
	wr_after_reset: assert property (@(posedge adc_clk) reset_bufs_A |=> !wr_o)
	else
	begin
		$error("wr_o high in the cycle after reset");
		fail_cnt++;
	end

	done_one_cycle: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		frame_done_o |=> !frame_done_o)
	else
	begin
		$error("frame_done_o held for more than one cycle");
		fail_cnt++;
	end

	// channel and word index stay inside the latched sample
	index_in_range: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		int'(chan_o) < RX_CHANS && int'(word_o) < WORDS_PER_CHAN)
	else
	begin
		$error("chan_o or word_o out of range");
		fail_cnt++;
	end

endmodule

bind xfer_sequencer tb_rx_buffer_assertions seq_chk_i (
	.adc_clk      (adc_clk),
	.reset_bufs_A (reset_bufs_A),
	.wr_o         (wr_o),
	.chan_o       (chan_o),
	.word_o       (word_o),
	.frame_done_o (frame_done_o)
);

`default_nettype wire

/* rx_buffer_top.sv */
////////////////////////////////////////////////////////////////////////////
// single clock; reset_bufs_A doubles as the buffer reset command
// rx_avail_i pulses must be >= 20 cycles apart, there is no back-pressure
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rx_buffer_top (
	input  wire                                             adc_clk,
	input  wire                                             reset_bufs_A,

	// DDC side
	input  wire                                             rx_avail_i,
	input  wire [rx_pkg::RX_CHANS*rx_pkg::CHAN_IQ_BITS-1:0] chan_iq_i,
	input  wire [rx_pkg::TICKS_BITS-1:0]                    ticks_i,

	// host commands
	input  wire                                             set_nsamps_i,
	input  wire [rx_pkg::NSAMPS_BITS-1:0]                   nsamps_i,
	input  wire                                             get_samp_i,
	input  wire                                             get_buf_ctr_i,
	input  wire                                             get_srq_i,

	// host read data
	output logic                                            rx_rd_o,
	output logic [rx_pkg::WORD_BITS-1:0]                    rx_dout_o,
	output logic                                            srq_o
);
	import rx_pkg::*;

	logic                  wr;          // sequencer write strobe
	logic [CHAN_BITS-1:0]  chan;        // channel being copied
	logic [1:0]            word;        // I/Q/IQ3 or ticks slice index
	word_src_t             src;
	logic                  frame_done;  // one cycle, after the counter word
	logic [WORD_BITS-1:0]  buf_ctr;
	logic [WORD_BITS-1:0]  wdata;
	logic [WORD_BITS-1:0]  ram_rdata;
	logic                  rd_adv;

	xfer_sequencer seq_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.set_nsamps_i (set_nsamps_i),
		.nsamps_i     (nsamps_i),
		.wr_o         (wr),
		.chan_o       (chan),
		.word_o       (word),
		.src_o        (src),
		.frame_done_o (frame_done),
		.buf_ctr_o    (buf_ctr)
	);

	frame_word_mux mux_i (
		.adc_clk    (adc_clk),
		.rx_avail_i (rx_avail_i),
		.chan_iq_i  (chan_iq_i),
		.ticks_i    (ticks_i),
		.chan_i     (chan),
		.word_i     (word),
		.src_i      (src),
		.buf_ctr_i  (buf_ctr),
		.wdata_o    (wdata)
	);

	sample_ram ram_i (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_i         (wr),
		.wdata_i      (wdata),
		.rd_adv_i     (rd_adv),
		.rdata_o      (ram_rdata)
	);

	host_read_port host_i (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.get_samp_i    (get_samp_i),
		.get_buf_ctr_i (get_buf_ctr_i),
		.get_srq_i     (get_srq_i),
		.frame_done_i  (frame_done),
		.buf_ctr_i     (buf_ctr),
		.ram_rdata_i   (ram_rdata),
		.rd_adv_o      (rd_adv),
		.rx_rd_o       (rx_rd_o),
		.rx_dout_o     (rx_dout_o),
		.srq_o         (srq_o)
	);

endmodule

`default_nettype wire

/* host_read_port.sv */
////////////////////////////////////////////////////////////////////////////
// one strobe per cycle; get_samp_i and get_buf_ctr_i must not coincide
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module host_read_port (
	input  wire                             adc_clk,
	input  wire                             reset_bufs_A,
	input  wire                             get_samp_i,
	input  wire                             get_buf_ctr_i,
	input  wire                             get_srq_i,
	input  wire                             frame_done_i,
	input  wire  [rx_pkg::WORD_BITS-1:0]    buf_ctr_i,
	input  wire  [rx_pkg::WORD_BITS-1:0]    ram_rdata_i,
	output logic                            rd_adv_o,
	output logic                            rx_rd_o,
	output logic [rx_pkg::WORD_BITS-1:0]    rx_dout_o,
	output logic                            srq_o
);
	import rx_pkg::*;

	logic                 sel_ctr_q;    // this read returns the counter
	logic [WORD_BITS-1:0] ctr_q;        // counter snapshot for the host
	logic                 pending_q;    // frame done since last srq query

	assign rd_adv_o = get_samp_i;       // RAM word is registered on this same edge

	always_ff @(posedge adc_clk)
	begin
		if (get_buf_ctr_i)
			ctr_q <= buf_ctr_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// read strobe and service request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			rx_rd_o   <= 1'b0;
			sel_ctr_q <= 1'b0;
			pending_q <= 1'b0;
			srq_o     <= 1'b0;
		end
		else
		begin
			rx_rd_o   <= get_samp_i | get_buf_ctr_i;   // data valid in the cycle after the strobe
			sel_ctr_q <= get_buf_ctr_i;
			if (get_srq_i)
			begin
				srq_o     <= pending_q;
				pending_q <= frame_done_i;  // a frame ending right now stays pending
			end
			else
				pending_q <= pending_q | frame_done_i;
		end
	end

	assign rx_dout_o = sel_ctr_q ? ctr_q : ram_rdata_i;

endmodule

`default_nettype wire

/* sample_ram.sv */
////////////////////////////////////////////////////////////////////////////
// 8k x 16 ring; a reader more than 8192 words behind loses data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sample_ram (
	input  wire                             adc_clk,
	input  wire                             reset_bufs_A,
	input  wire                             wr_i,
	input  wire  [rx_pkg::WORD_BITS-1:0]    wdata_i,
	input  wire                             rd_adv_i,
	output logic [rx_pkg::WORD_BITS-1:0]    rdata_o
);
	import rx_pkg::*;

	logic [WORD_BITS-1:0]     mem [0:(1 << RAM_ADDR_BITS)-1];
	logic [RAM_ADDR_BITS-1:0] waddr_q;  // next word to write
	logic [RAM_ADDR_BITS-1:0] raddr_q;  // next unread word

	// block RAM style port pair
	always_ff @(posedge adc_clk)
	begin
		if (wr_i)
			mem[waddr_q] <= wdata_i;
		rdata_o <= mem[raddr_q];    // registered, sampled before the read counter moves
	end

	////////////////////////////////////////////////////////////////////////////
	// address counters, both wrap
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			waddr_q <= '0;
			raddr_q <= '0;
		end
		else
		begin
			waddr_q <= waddr_q + RAM_ADDR_BITS'(wr_i);
			raddr_q <= raddr_q + RAM_ADDR_BITS'(rd_adv_i);
		end
	end

endmodule

`default_nettype wire

/* frame_word_mux.sv */
////////////////////////////////////////////////////////////////////////////
// channel and ticks inputs are sampled only on rx_avail_i
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module frame_word_mux (
	input  wire                                             adc_clk,
	input  wire                                             rx_avail_i,
	input  wire [rx_pkg::RX_CHANS*rx_pkg::CHAN_IQ_BITS-1:0] chan_iq_i,
	input  wire [rx_pkg::TICKS_BITS-1:0]                    ticks_i,
	input  wire [rx_pkg::CHAN_BITS-1:0]                     chan_i,
	input  wire [1:0]                                       word_i,
	input  wire rx_pkg::word_src_t                          src_i,
	input  wire [rx_pkg::WORD_BITS-1:0]                     buf_ctr_i,
	output logic [rx_pkg::WORD_BITS-1:0]                    wdata_o
);
	import rx_pkg::*;

	// packed view matches the input layout: [chan][word][bit], I is word 0
	logic [RX_CHANS-1:0][WORDS_PER_CHAN-1:0][WORD_BITS-1:0] iq_q;
	logic [WORDS_PER_CHAN-1:0][WORD_BITS-1:0]               ticks_q;   // lsw in slice 0

	////////////////////////////////////////////////////////////////////////////
	// hold one sample for the whole multi-cycle copy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
		begin
			iq_q    <= chan_iq_i;
			ticks_q <= ticks_i;     // only used on the closing sample
		end
	end

	// write data follows the sequencer outputs in the same cycle
	always_comb
	begin
		case (src_i)
			SRC_CHAN:  wdata_o = iq_q[chan_i][word_i];
			SRC_TICKS: wdata_o = ticks_q[word_i];
			SRC_CTR:   wdata_o = buf_ctr_i;     // value before the increment
			default:   wdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* xfer_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// rx_avail_i is ignored while a transfer runs; nsamps = 0 is not supported
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module xfer_sequencer (
	input  wire                           adc_clk,
	input  wire                           reset_bufs_A,
	input  wire                           rx_avail_i,
	input  wire                           set_nsamps_i,
	input  wire [rx_pkg::NSAMPS_BITS-1:0] nsamps_i,
	output logic                          wr_o,
	output logic [rx_pkg::CHAN_BITS-1:0]  chan_o,
	output logic [1:0]                    word_o,
	output rx_pkg::word_src_t             src_o,
	output logic                          frame_done_o,
	output logic [rx_pkg::WORD_BITS-1:0]  buf_ctr_o
);
	import rx_pkg::*;

	logic                    xfer_q;    // copy in progress
	logic                    gap_q;     // idle cycle before the ticks words
	logic [NSAMPS_BITS-1:0]  count_q;   // samples already copied into this frame
	logic [NSAMPS_BITS-1:0]  nsamps_q;  // samples per frame

	wire last_word = (word_o == 2'(WORDS_PER_CHAN - 1));
	wire last_chan = (chan_o == CHAN_BITS'(RX_CHANS - 1));

	wire [NSAMPS_BITS-1:0] count_inc = count_q + 1'b1;
	wire last_samp = (count_inc == nsamps_q);    // this sample closes the frame

	// host setting, survives a buffer reset
	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps_i)
			nsamps_q <= nsamps_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// transfer FSM
	//   sample:  ch0 I Q IQ3 .. ch3 I Q IQ3                   12 writes
	//   closing: same 12, idle, ticks[15:0] [31:16] [47:32], buf_ctr
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		frame_done_o <= 1'b0;   // pulse only

		if (reset_bufs_A)
		begin
			xfer_q    <= 1'b0;
			gap_q     <= 1'b0;
			wr_o      <= 1'b0;
			chan_o    <= '0;
			word_o    <= '0;
			src_o     <= SRC_CHAN;
			count_q   <= '0;
			buf_ctr_o <= '0;
		end
		else if (!xfer_q)
		begin
			// first write lands the cycle after the pulse, mux latches at the same edge
			if (rx_avail_i)
			begin
				xfer_q <= 1'b1;
				wr_o   <= 1'b1;
				chan_o <= '0;
				word_o <= '0;
				src_o  <= SRC_CHAN;
			end
		end
		else if (gap_q)
		begin
			gap_q  <= 1'b0;
			wr_o   <= 1'b1;        // resume with the ticks words
			src_o  <= SRC_TICKS;
			word_o <= '0;
		end
		else
		begin
			case (src_o)
				SRC_CHAN:
				begin
					if (!last_word)
						word_o <= word_o + 1'b1;
					else
					begin
						word_o <= '0;
						if (!last_chan)
							chan_o <= chan_o + 1'b1;
						else
						begin
							// all channels moved
							wr_o   <= 1'b0;
							chan_o <= '0;
							if (last_samp)
								gap_q <= 1'b1;  // keep xfer_q, timestamp follows
							else
							begin
								xfer_q  <= 1'b0;    // wait for next sample
								count_q <= count_inc;
							end
						end
					end
				end

				SRC_TICKS:
				begin
					if (last_word)
					begin
						word_o <= '0;
						src_o  <= SRC_CTR;  // single counter word next
					end
					else
						word_o <= word_o + 1'b1;
				end

				SRC_CTR:
				begin
					// counter word written this cycle, frame is closed
					wr_o         <= 1'b0;
					xfer_q       <= 1'b0;
					count_q      <= '0;
					src_o        <= SRC_CHAN;
					frame_done_o <= 1'b1;
					buf_ctr_o    <= buf_ctr_o + 1'b1;
				end

				default:
				begin
					wr_o   <= 1'b0;   // unused code, drop the transfer
					xfer_q <= 1'b0;
					src_o  <= SRC_CHAN;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rx_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// sizes assume 4 audio channels of 3 words each and a 13-bit (8k) buffer
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package rx_pkg;

	// audio channel layout
	localparam int RX_CHANS       = 4;      // number of DDC audio channels
	localparam int CHAN_BITS      = 2;      // channel index width
	localparam int WORD_BITS      = 16;     // one buffer word
	localparam int WORDS_PER_CHAN = 3;      // I, Q, IQ3
	localparam int CHAN_IQ_BITS   = 48;     // I in low, Q in middle, IQ3 in high word

	// frame closing data
	localparam int TICKS_BITS     = 48;     // timestamp, written as 3 words lsw first
	localparam int NSAMPS_BITS    = 7;      // samples per frame

	// shared sample buffer
	localparam int RAM_ADDR_BITS  = 13;     // 8192 words, addresses wrap

	////////////////////////////////////////////////////////////////////////////
	// source of the word being written into the buffer
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		SRC_CHAN  = 2'd0,   // channel I/Q/IQ3 word
		SRC_TICKS = 2'd1,   // timestamp slice
		SRC_CTR   = 2'd2    // buffer counter, last word of a frame
	} word_src_t;

	// code 2'd3 is never driven, the mux writes zero for it

endpackage

`default_nettype wire
